//--- sources.f
+incdir+hdl
hdl/cpu11_pkg.sv
hdl/instr_decoder.sv
hdl/bus_timer.sv
hdl/reg_file.sv
hdl/alu11.sv
hdl/cpu11_sequencer.sv
hdl/cpu11_top.sv
testbench/cpu11_monitor.sv
testbench/cpu11_chk.sv
testbench/cpu11_tb.sv

//--- testbench/cpu11_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu11_tb
	import cpu11_pkg::*;
();

	localparam int XFER_GOAL = 300;
	localparam int WAIT_LIMIT = 20000;
	localparam logic [31:0] SEED = 32'd98394;

	logic clk = 1'b0;
	logic reset_n;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	word_t mem [4096];
	logic [31:0] wait_state;
	logic wait_en;
	logic hang_en;
	word_t hang_addr;
	logic busy;
	int wait_left;
	int tests_run;
	int timeouts;
	int total_err;

	always #10 clk = ~clk;

	cpu11_top DUT (.clk, .reset_n, .bus_req, .bus_rsp);

	cpu11_monitor MON (.clk, .reset_n, .bus_req, .bus_rsp, .hang_en, .hang_addr);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t make_instr(input logic [31:0] r, input bit deferred,
			input bit branches, input bit illegal);
		logic [3:0] op4;
		logic [2:0] dreg;
		logic smode;
		logic dmode;
		op4 = (r[9:8] == 2'd0) ? 4'h1 : (r[9:8] == 2'd1) ? 4'h2 : (r[9:8] == 2'd2) ? 4'h6 : 4'he;
		// pc never a destination
		dreg = (r[18:16] == 3'd7) ? 3'd0 : r[18:16];
		smode = deferred & r[20];
		dmode = deferred & r[21];
		if (branches && r[3:0] < 4'd3)
			return {8'h01 + 8'(r[5:4] % 2'd3), {4{r[11]}}, r[11:8]};
		if (illegal && r[3:0] == 4'd3)
			return {8'h00, r[7:0]};
		if (r[0])
			return {8'h0a, r[7:6], 2'b00, dmode, dreg};
		return {op4, 2'b00, smode, r[24:22], 2'b00, dmode, dreg};
	endfunction

	// code in the lower half and data words above
	task automatic load_image(input logic [31:0] seed, input bit deferred,
			input bit branches, input bit illegal);
		logic [31:0] s;
		word_t w;
		s = seed;
		for (int i = 0; i < 4096; i++) begin
			s = xorshift(s);
			if (i < 2048)
				w = make_instr(s, deferred, branches, illegal);
			else
				w = s[15:0] ^ s[31:16];
			// vector words that also act as branches with zero offset
			if (i == 2)
				w = 16'o1000;
			if (i == 4)
				w = 16'o1400;
			mem[i] = w;
			MON.write_word(i, w);
		end
	endtask

	// memory model answering on the falling edge
	always @(negedge clk) begin
		if (!reset_n || bus_rsp.ready) begin
			bus_rsp.ready = 1'b0;
			busy = 1'b0;
		end else if (bus_req.rd || bus_req.wr) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = 0;
				if (wait_en) begin
					wait_state = xorshift(wait_state);
					wait_left = int'(wait_state % 4);
				end
			end
			if (!(hang_en && bus_req.addr[12:1] == hang_addr[12:1])) begin
				if (wait_left > 0) begin
					wait_left--;
				end else begin
					bus_rsp.ready = 1'b1;
					bus_rsp.rdata = mem[bus_req.addr[12:1]];
					if (bus_req.wr)
						mem[bus_req.addr[12:1]] = bus_req.wdata;
				end
			end
		end else begin
			busy = 1'b0;
		end
	end

	task automatic run_test(input int num, input string name, input logic [31:0] seed,
			input bit deferred, input bit branches, input bit illegal,
			input bit waits, input bit hang);
		int err0;
		int n;
		@(negedge clk);
		reset_n = 1'b0;
		wait_en = waits;
		hang_en = hang;
		hang_addr = 16'o100;
		load_image(seed, deferred, branches, illegal);
		repeat (3) @(negedge clk);
		reset_n = 1'b1;
		err0 = MON.err_count + DUT.u_chk.fail_count;
		n = 0;
		while (MON.xfer_count < XFER_GOAL && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		tests_run++;
		if (MON.xfer_count < XFER_GOAL) begin
			timeouts++;
			$display("test %0d (%s) timed out after %0d cycles with %0d of %0d bus transfers",
				num, name, n, MON.xfer_count, XFER_GOAL);
		end else begin
			$display("test %0d (%s): %0d transfers, %0d errors", num, name, MON.xfer_count,
				MON.err_count + DUT.u_chk.fail_count - err0);
		end
	endtask

	initial begin
		reset_n = 1'b0;
		bus_rsp = '0;
		wait_en = 1'b0;
		hang_en = 1'b0;
		hang_addr = '0;
		busy = 1'b0;
		wait_left = 0;
		wait_state = SEED;
		tests_run = 0;
		timeouts = 0;
		run_test(1, "register mode", SEED, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		run_test(2, "deferred mode", SEED ^ 32'h1111, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		run_test(3, "branches", SEED ^ 32'h2222, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
		// same image as test 3
		run_test(4, "branches with wait states", SEED ^ 32'h2222, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
		run_test(5, "bus timeout trap", SEED ^ 32'h3333, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		run_test(6, "illegal instruction trap", SEED ^ 32'h4444, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
		total_err = MON.err_count + DUT.u_chk.fail_count + timeouts;
		$display("%0d tests run, %0d errors", tests_run, total_err);
		if (total_err == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/cpu11_chk.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu11_consts.svh"

module cpu11_chk
	import cpu11_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire bus_req_t bus_req,
	input wire bus_rsp_t bus_rsp,
	input wire timeout
);

	int fail_count = 0;
	logic open;

	assign open = bus_req.rd | bus_req.wr;

	a_strobe_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(bus_req.rd && bus_req.wr))
		else begin
			fail_count++;
			$error("read and write strobes high together");
		end

	a_addr_stable: assert property (@(posedge clk) disable iff (!reset_n)
		open && !bus_rsp.ready && !timeout |=> $stable(bus_req.addr) && $stable(bus_req.wdata))
		else begin
			fail_count++;
			$error("address or data changed in a waiting cycle");
		end

	a_idle_gap: assert property (@(posedge clk) disable iff (!reset_n)
		open && bus_rsp.ready |=> !open)
		else begin
			fail_count++;
			$error("strobe still high after a transfer");
		end

	// timeout only after the full run of waiting cycles
	a_timeout_ready: assert property (@(posedge clk) disable iff (!reset_n)
		timeout |-> !bus_rsp.ready && $past(open && !bus_rsp.ready, `CPU11_BUS_TIMEOUT))
		else begin
			fail_count++;
			$error("timeout while ready is high or before the wait limit");
		end

	a_timeout_due: assert property (@(posedge clk) disable iff (!reset_n)
		(open && !bus_rsp.ready) [* `CPU11_BUS_TIMEOUT + 1] |-> timeout)
		else begin
			fail_count++;
			$error("no timeout after the wait limit");
		end

endmodule

bind cpu11_top cpu11_chk u_chk (
	.clk(clk), .reset_n(reset_n), .bus_req(bus_req), .bus_rsp(bus_rsp), .timeout(timeout)
);

`default_nettype wire

//--- testbench/cpu11_monitor.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu11_consts.svh"

module cpu11_monitor
	import cpu11_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire bus_req_t bus_req,
	input wire bus_rsp_t bus_rsp,
	input wire hang_en,
	input wire word_t hang_addr
);

	int xfer_count = 0;
	int err_count = 0;

	// model registers with r[7] as the pc
	word_t mem [4096];
	word_t r [8];
	logic z;
	bus_req_t exp_q [$];

	task automatic write_word(input int idx, input word_t w);
		mem[idx] = w;
	endtask

	// predicts one bus cycle and clears ok when the memory never answers
	task automatic access(input logic wr, input word_t a, input word_t wd,
			output word_t rd, output bit ok);
		bus_req_t c;
		rd = '0;
		ok = !(hang_en && (a[12:1] == hang_addr[12:1]));
		if (ok) begin
			c.addr = a;
			c.wdata = wr ? wd : word_t'(0);
			c.rd = !wr;
			c.wr = wr;
			exp_q.push_back(c);
			if (wr)
				mem[a[12:1]] = wd;
			else
				rd = mem[a[12:1]];
		end
	endtask

	task automatic take_trap(input word_t vec);
		word_t v;
		word_t d;
		bit ok;
		v = vec;
		for (int n = 0; n < 4; n++) begin
			access(1'b0, v, '0, d, ok);
			if (ok) begin
				r[7] = d;
				z = 1'b0;
				return;
			end
			// timeout on the vector read traps again
			v = `CPU11_VEC_BUSERR;
		end
	endtask

	task automatic run_instr();
		word_t ir;
		word_t src;
		word_t dst;
		word_t ea;
		word_t res;
		word_t d;
		bit ok;
		logic is_dop;
		logic is_sop;
		logic taken;
		access(1'b0, r[7], '0, ir, ok);
		if (!ok) begin
			take_trap(`CPU11_VEC_BUSERR);
			return;
		end
		r[7] = r[7] + 16'd2;
		is_dop = (ir[15:12] inside {4'h1, 4'h2, 4'h6, 4'he}) && ir[11:10] == 2'b00
			&& ir[5:4] == 2'b00;
		is_sop = (ir[15:8] == 8'h0a) && ir[5:4] == 2'b00;
		if (ir[15:8] inside {8'h01, 8'h02, 8'h03}) begin
			// bne branches on z clear, beq on z set
			case (ir[9:8])
				2'd2: taken = !z;
				2'd3: taken = z;
				default: taken = 1'b1;
			endcase
			if (taken)
				r[7] = r[7] + {{7{ir[7]}}, ir[7:0], 1'b0};
			return;
		end
		if (!is_dop && !is_sop) begin
			take_trap(`CPU11_VEC_ILLEGAL);
			return;
		end
		src = r[ir[8:6]];
		if (is_dop && ir[9]) begin
			access(1'b0, r[ir[8:6]], '0, src, ok);
			if (!ok) begin
				take_trap(`CPU11_VEC_BUSERR);
				return;
			end
		end
		ea = r[ir[2:0]];
		dst = ea;
		if (ir[3]) begin
			access(1'b0, ea, '0, dst, ok);
			if (!ok) begin
				take_trap(`CPU11_VEC_BUSERR);
				return;
			end
		end
		if (is_dop) begin
			case (ir[15:12])
				4'h1: res = src;
				4'h6: res = src + dst;
				default: res = dst - src;
			endcase
		end else begin
			case (ir[7:6])
				2'd0: res = '0;
				2'd1: res = ~dst;
				2'd2: res = dst + 16'd1;
				default: res = dst - 16'd1;
			endcase
		end
		z = (res == '0);
		// cmp only sets z
		if (is_dop && ir[15:12] == 4'h2)
			return;
		if (ir[3]) begin
			access(1'b1, ea, res, d, ok);
			if (!ok)
				take_trap(`CPU11_VEC_BUSERR);
		end else begin
			r[ir[2:0]] = res;
		end
	endtask

	task automatic check_transfer();
		bus_req_t e;
		if (exp_q.size() == 0)
			run_instr();
		xfer_count++;
		if (exp_q.size() == 0) begin
			err_count++;
			$display("ERROR at %0t: no bus cycle predicted for transfer %0d", $time, xfer_count);
			return;
		end
		e = exp_q.pop_front();
		if (e.wr != bus_req.wr || e.addr != bus_req.addr
				|| (e.wr && e.wdata != bus_req.wdata)) begin
			err_count++;
			$display("ERROR at %0t: transfer %0d expected %s %o data %o, got %s %o data %o",
				$time, xfer_count, e.wr ? "write" : "read", e.addr, e.wdata,
				bus_req.wr ? "write" : "read", bus_req.addr, bus_req.wdata);
		end
	endtask

	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 8; i++)
				r[i] = '0;
			z = 1'b0;
			exp_q.delete();
			xfer_count = 0;
		end else if ((bus_req.rd || bus_req.wr) && bus_rsp.ready) begin
			check_transfer();
		end
	end

endmodule

`default_nettype wire

//--- hdl/cpu11_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu11_top
	import cpu11_pkg::*;
(
	input wire clk,
	input wire reset_n,
	output bus_req_t bus_req,
	input wire bus_rsp_t bus_rsp
);

	word_t instr;
	word_t rd_a;
	word_t rd_b;
	word_t wr_data;
	word_t alu_a;
	word_t alu_b;
	decoded_t decoded;
	alu_out_t alu_out;
	alu_op_e alu_op;
	reg_idx_t sel_a;
	reg_idx_t sel_b;
	reg_idx_t wr_sel;
	logic wr_en;
	logic bus_open;
	logic timeout;

	cpu11_sequencer u_seq (
		.clk, .reset_n, .decoded, .alu_out, .rd_a, .rd_b, .timeout, .bus_rsp,
		.instr, .bus_req, .bus_open, .sel_a, .sel_b, .wr_sel, .wr_en, .wr_data,
		.alu_op, .alu_a, .alu_b
	);

	instr_decoder u_dec (.instr, .decoded);

	// stands in for an external bus error line
	bus_timer u_timer (.clk, .reset_n, .bus_open, .ready(bus_rsp.ready), .timeout);

	reg_file u_regs (.clk, .reset_n, .sel_a, .sel_b, .rd_a, .rd_b, .wr_sel, .wr_en, .wr_data);

	alu11 u_alu (.alu_op, .alu_a, .alu_b, .alu_out);

endmodule

`default_nettype wire

//--- hdl/cpu11_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu11_consts.svh"

module cpu11_sequencer
	import cpu11_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire decoded_t decoded,
	input wire alu_out_t alu_out,
	input wire word_t rd_a,
	input wire word_t rd_b,
	input wire timeout,
	input wire bus_rsp_t bus_rsp,
	output word_t instr,
	output bus_req_t bus_req,
	output logic bus_open,
	output reg_idx_t sel_a,
	output reg_idx_t sel_b,
	output reg_idx_t wr_sel,
	output logic wr_en,
	output word_t wr_data,
	output alu_op_e alu_op,
	output word_t alu_a,
	output word_t alu_b
);

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_SRC, S_DST, S_EXEC, S_WB, S_TRAP
	} state_e;

	localparam reg_idx_t PC_IDX = 3'd7;

	state_e state;
	logic req_rd;
	logic req_wr;
	logic z;
	word_t req_addr;
	word_t src_q;
	word_t dst_q;
	word_t ea_q;
	word_t res_q;
	word_t vec_q;
	word_t open_addr;
	word_t br_disp;
	logic need_rd;
	logic open_rd;
	logic open_wr;
	logic xfer;
	logic taken;

	assign bus_open = req_rd | req_wr;
	assign xfer = bus_open & bus_rsp.ready;
	assign bus_req = '{addr: req_addr, wdata: res_q, rd: req_rd, wr: req_wr};

	assign alu_op = decoded.op;
	assign alu_a = src_q;
	assign alu_b = dst_q;

	assign sel_a = (state == S_SRC) ? decoded.src_reg : PC_IDX;
	assign sel_b = decoded.dst_reg;

	// word offset, doubled
	assign br_disp = {{(`CPU11_WORD_W - 9){decoded.br_off[7]}}, decoded.br_off, 1'b0};

	always_comb begin
		case (decoded.br_cond)
			BR_ZSET: taken = z;
			BR_ZCLR: taken = ~z;
			default: taken = 1'b1;
		endcase
	end

	// ========================================
	// bus cycle requests
	// ========================================

	always_comb begin
		need_rd = 1'b0;
		open_addr = rd_a;
		case (state)
			S_FETCH: need_rd = 1'b1;
			S_SRC: need_rd = decoded.src_mode;
			S_DST: begin
				need_rd = decoded.dst_mode;
				open_addr = rd_b;
			end
			S_WB: open_addr = ea_q;
			S_TRAP: begin
				need_rd = 1'b1;
				open_addr = vec_q;
			end
			default: ;
		endcase
	end

	// a new cycle opens only after a cycle with both strobes low
	assign open_rd = need_rd & ~bus_open;
	assign open_wr = (state == S_WB) & decoded.dst_mode & ~bus_open;

	// ========================================
	// register file writes
	// ========================================

	always_comb begin
		wr_en = 1'b0;
		wr_sel = PC_IDX;
		wr_data = rd_a + word_t'(2);
		case (state)
			S_FETCH: wr_en = xfer;
			S_DECODE: begin
				wr_en = (decoded.cls == CLS_BRANCH) & taken;
				wr_data = rd_a + br_disp;
			end
			S_WB: begin
				wr_en = ~decoded.dst_mode;
				wr_sel = decoded.dst_reg;
				wr_data = res_q;
			end
			S_TRAP: begin
				wr_en = xfer;
				wr_data = bus_rsp.rdata;
			end
			default: ;
		endcase
	end

	// ========================================
	// control state
	// ========================================

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= S_FETCH;
			req_rd <= 1'b0;
			req_wr <= 1'b0;
			z <= 1'b0;
		end else begin
			if (xfer || timeout) begin
				req_rd <= 1'b0;
				req_wr <= 1'b0;
			end else begin
				if (open_rd)
					req_rd <= 1'b1;
				if (open_wr)
					req_wr <= 1'b1;
			end

			if (timeout) begin
				state <= S_TRAP;
			end else begin
				case (state)
					S_FETCH: if (xfer) state <= S_DECODE;
					S_DECODE: begin
						case (decoded.cls)
							CLS_DOP: state <= S_SRC;
							CLS_SOP: state <= S_DST;
							CLS_BRANCH: state <= S_FETCH;
							default: state <= S_TRAP;
						endcase
					end
					S_SRC: if (!decoded.src_mode || xfer) state <= S_DST;
					S_DST: if (!decoded.dst_mode || xfer) state <= S_EXEC;
					S_EXEC: begin
						z <= alu_out.z;
						state <= decoded.wr_result ? S_WB : S_FETCH;
					end
					S_WB: if (!decoded.dst_mode || xfer) state <= S_FETCH;
					S_TRAP: begin
						// vector loaded into pc, flags cleared
						if (xfer) begin
							z <= 1'b0;
							state <= S_FETCH;
						end
					end
					default: state <= S_FETCH;
				endcase
			end
		end
	end

	// ========================================
	// instruction and operand latches
	// ========================================

	always_ff @(posedge clk) begin
		if (!bus_open)
			req_addr <= open_addr;
		if (state == S_FETCH && xfer)
			instr <= bus_rsp.rdata;
		// last load is at the transfer edge
		if (state == S_SRC)
			src_q <= decoded.src_mode ? bus_rsp.rdata : rd_a;
		if (state == S_DST) begin
			dst_q <= decoded.dst_mode ? bus_rsp.rdata : rd_b;
			ea_q <= rd_b;
		end
		if (state == S_EXEC)
			res_q <= alu_out.result;
		if (timeout)
			vec_q <= `CPU11_VEC_BUSERR;
		else if (state == S_DECODE && decoded.cls == CLS_ILLEGAL)
			vec_q <= `CPU11_VEC_ILLEGAL;
	end

endmodule

`default_nettype wire

//--- hdl/alu11.sv
`timescale 1ns/10ps
`default_nettype none

module alu11
	import cpu11_pkg::*;
(
	input wire alu_op_e alu_op,
	input wire word_t alu_a,
	input wire word_t alu_b,
	output alu_out_t alu_out
);

	// alu_a carries the source, alu_b the destination
	word_t res;

	always_comb begin
		case (alu_op)
			ALU_PASS: res = alu_a;
			ALU_ADD: res = alu_a + alu_b;
			// dst - src, as on the pdp-11
			ALU_SUB: res = alu_b - alu_a;
			ALU_CLR: res = '0;
			ALU_COM: res = ~alu_b;
			ALU_INC: res = alu_b + word_t'(1);
			ALU_DEC: res = alu_b - word_t'(1);
			default: res = alu_a;
		endcase
	end

	assign alu_out = '{result: res, z: (res == '0)};

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu11_consts.svh"

module reg_file
	import cpu11_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire reg_idx_t sel_a,
	input wire reg_idx_t sel_b,
	output word_t rd_a,
	output word_t rd_b,
	input wire reg_idx_t wr_sel,
	input wire wr_en,
	input wire word_t wr_data
);

	// r0..r6 general, r7 is the pc
	word_t regs [8];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 7; i++)
				regs[i] <= '0;
			regs[7] <= `CPU11_RESET_PC;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	assign rd_a = regs[sel_a];
	assign rd_b = regs[sel_b];

endmodule

`default_nettype wire

//--- hdl/bus_timer.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu11_consts.svh"

module bus_timer (
	input wire clk,
	input wire reset_n,
	input wire bus_open,
	input wire ready,
	output logic timeout
);

	localparam int CNT_W = $clog2(`CPU11_BUS_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`CPU11_BUS_TIMEOUT);

	logic [CNT_W-1:0] count;

	// wait cycles of the open bus cycle, holds at the limit
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			count <= '0;
		else if (!bus_open || ready)
			count <= '0;
		else if (count != LIMIT)
			count <= count + 1'b1;
	end

	assign timeout = bus_open & ~ready & (count == LIMIT);

endmodule

`default_nettype wire

//--- hdl/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
	import cpu11_pkg::*;
(
	input wire word_t instr,
	output decoded_t decoded
);

	// only register and register deferred are supported
	logic src_ok;
	logic dst_ok;

	assign src_ok = (instr[11:10] == 2'b00);
	assign dst_ok = (instr[5:4] == 2'b00);

	always_comb begin
		decoded = '0;
		decoded.cls = CLS_ILLEGAL;
		decoded.op = ALU_PASS;
		decoded.wr_result = 1'b1;
		decoded.src_mode = instr[9];
		decoded.src_reg = instr[8:6];
		decoded.dst_mode = instr[3];
		decoded.dst_reg = instr[2:0];
		decoded.br_cond = BR_ALWAYS;
		decoded.br_off = instr[7:0];

		case (instr[15:12])
			// double operand group
			4'h1: decoded.op = ALU_PASS;
			4'h2: begin
				decoded.op = ALU_SUB;
				decoded.wr_result = 1'b0;
			end
			4'h6: decoded.op = ALU_ADD;
			4'he: decoded.op = ALU_SUB;
			default: ;
		endcase

		if (instr[15:12] inside {4'h1, 4'h2, 4'h6, 4'he}) begin
			if (src_ok && dst_ok)
				decoded.cls = CLS_DOP;
		end else if (instr[15:8] == 8'h0a) begin
			// clr com inc dec at 0050dd to 0053dd
			decoded.op = alu_op_e'({1'b0, instr[7:6]} + 3'd3);
			if (dst_ok)
				decoded.cls = CLS_SOP;
		end else if (instr[15:8] inside {8'h01, 8'h02, 8'h03}) begin
			decoded.cls = CLS_BRANCH;
			// br at 0004xx, bne at 0010xx, beq at 0014xx
			case (instr[9:8])
				2'd2: decoded.br_cond = BR_ZCLR;
				2'd3: decoded.br_cond = BR_ZSET;
				default: decoded.br_cond = BR_ALWAYS;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/cpu11_pkg.sv
`default_nettype none
`include "cpu11_consts.svh"

package cpu11_pkg;

	typedef logic [`CPU11_WORD_W-1:0] word_t;
	typedef logic [2:0] reg_idx_t;

	typedef enum logic [2:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_CLR, ALU_COM, ALU_INC, ALU_DEC
	} alu_op_e;

	typedef enum logic [1:0] {CLS_DOP, CLS_SOP, CLS_BRANCH, CLS_ILLEGAL} instr_class_e;

	// branch condition on the Z flag
	typedef enum logic [1:0] {BR_ALWAYS, BR_ZSET, BR_ZCLR} br_cond_e;

	typedef struct packed {
		instr_class_e cls;
		alu_op_e op;
		logic wr_result;
		logic src_mode;
		reg_idx_t src_reg;
		logic dst_mode;
		reg_idx_t dst_reg;
		br_cond_e br_cond;
		logic [7:0] br_off;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic rd;
		logic wr;
	} bus_req_t;

	typedef struct packed {
		word_t rdata;
		logic ready;
	} bus_rsp_t;

	typedef struct packed {
		word_t result;
		logic z;
	} alu_out_t;

endpackage

`default_nettype wire

//--- hdl/cpu11_consts.svh
`ifndef CPU11_CONSTS_SVH
`define CPU11_CONSTS_SVH

// ========================================
// machine word and bus
// ========================================

// data and address width
`define CPU11_WORD_W 16

// first fetch address after reset
`define CPU11_RESET_PC 16'o0

// wait cycles before an open bus cycle is abandoned
`define CPU11_BUS_TIMEOUT 12

// trap vectors
`define CPU11_VEC_BUSERR 16'o4
`define CPU11_VEC_ILLEGAL 16'o10

`endif
